// File: dv/tb_clk_gen.sv
/*
 * Testbench clock and reset
 *   - 4 ns clock period
 *   - active-low reset held for 10 cycles
 */
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;       // 4 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;             // Release just after an edge
  end

endmodule

// File: dv/tb_dma_rd.sv
/*
 * Testbench for the DMA read-request path
 *   - DUT dma_rd_top, clock and reset from tb_clk_gen
 *   - completion responder with random gaps
 *   - burst reference function, compare process, check task, timeout
 */
`timescale 1ns/10ps

module tb_dma_rd
  import dma_rd_pkg::*;
();

  // Expected outputs for one comparison
  typedef struct packed {
    logic [31:0] req_cnt;
    logic [31:0] cpl_dw;
    logic [31:0] hwm_cnt;
    logic [31:0] req_seen;
    logic        done;
    logic        err;
    logic        chk_hwm;
    logic        chk_seen;
    logic        chk_runs;   // Strobes must form one unbroken run
  } expect_t;

  logic             clk;
  logic             rst_n;
  logic             init_i;
  logic             start_i;
  rd_cfg_t          cfg_i;
  cpl_t             cpl_i;
  logic             req_o;
  logic [CNT_W-1:0] req_cnt_o;
  logic [DW_W-1:0]  cpl_dw_o;
  logic [CNT_W-1:0] hwm_cnt_o;
  logic             done_o;
  logic             err_o;

  int      seed;
  int      err_cnt;
  int      err_base;
  int      tests_run;
  int      tests_failed;
  int      cycle_cnt;
  int      cycle_limit;
  int      pending;          // Requests still owed a completion
  int      gap_left;
  int      req_seen;
  int      req_runs;
  int      idle_cnt;
  logic    req_prev;
  logic    resp_en;
  int      bad_kind;         // 0 none, 1 poisoned, 2 zero length
  logic    meter_mon;
  logic    dw_mon;
  int      dw_ref;           // Completion DWs the tracker should hold
  int      dw_target;
  logic    cmp_req;
  expect_t exp_q;
  cpl_t    cpl_next;
  int      sweep_len [6];

  tb_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  dma_rd_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .init_i    (init_i),
    .start_i   (start_i),
    .cfg_i     (cfg_i),
    .cpl_i     (cpl_i),
    .req_o     (req_o),
    .req_cnt_o (req_cnt_o),
    .cpl_dw_o  (cpl_dw_o),
    .hwm_cnt_o (hwm_cnt_o),
    .done_o    (done_o),
    .err_o     (err_o)
  );

  // ----------------------------------------------------------------------
  // Reference model and check
  // ----------------------------------------------------------------------
  // Initial burst in requests, table value plus the one sent before the load
  function automatic int burst_len(input int len, input logic rcb_128);
    int lim;
    int first;
    lim = int'(CPL_LIMIT);
    if (len == 1)
      first = lim;
    else if (len <= (rcb_128 ? 32 : 16))
      first = lim / 2;
    else if (len <= (rcb_128 ? 128 : 64))
      first = lim / 4;
    else
      first = lim / 8;
    return first + 1;
  endfunction

  function automatic int budget(input int len, input int total);
    return total * (len + 8);
  endfunction

  function automatic int sweep_total(input int len);
    return (len == 1) ? 5 : 20;     // Short run so the total caps the burst
  endfunction

  task automatic check(input string name, input logic [31:0] exp_val,
                       input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      $display("error at %0t: %s expected %0d, got %0d", $time, name, exp_val, act_val);
      err_cnt = err_cnt + 1;
    end
  endtask

  // ----------------------------------------------------------------------
  // Completion responder, one completion per request
  // ----------------------------------------------------------------------
  always @(negedge clk) begin
    cpl_next = '0;
    if (!resp_en) begin
      pending  = 0;
      gap_left = 0;
    end else begin
      if (req_o) pending = pending + 1;
      if (pending > 0) begin
        if (gap_left > 0) begin
          gap_left = gap_left - 1;
        end else begin
          cpl_next.valid    = 1'b1;
          cpl_next.len_dw   = (bad_kind == 2) ? '0 : cfg_i.len_dw;
          cpl_next.poisoned = (bad_kind == 1);
          bad_kind = 0;                                  // Only one bad completion
          pending  = pending - 1;
          gap_left = $unsigned($random(seed)) % 6;
        end
      end
    end
  end

  always @(posedge clk) begin
    #1 cpl_i = cpl_next;
  end

  // ----------------------------------------------------------------------
  // Compare process, samples mid-cycle
  // ----------------------------------------------------------------------
  always @(negedge clk) begin
    if (rst_n) begin
      if (req_o) begin
        if (!req_prev) req_runs = req_runs + 1;
        req_seen = req_seen + 1;
        idle_cnt = 0;
      end else begin
        idle_cnt = idle_cnt + 1;
      end
      req_prev = req_o;
      if (meter_mon && (int'(req_cnt_o) > int'(hwm_cnt_o) + 1)) begin
        $display("error at %0t: req_cnt_o %0d ran past hwm_cnt_o %0d plus one",
                 $time, req_cnt_o, hwm_cnt_o);
        err_cnt = err_cnt + 1;
      end
      // Tracker total lags the completion strobe by one edge
      if (dw_mon) begin
        check("cpl_dw_o", 32'(dw_ref), cpl_dw_o);
        check("done_o", 32'(dw_ref >= dw_target), 32'(done_o));
      end
      if (cpl_i.valid) dw_ref = dw_ref + int'(cpl_i.len_dw);
      if (cmp_req) begin
        check("req_cnt_o", exp_q.req_cnt, 32'(req_cnt_o));
        check("cpl_dw_o", exp_q.cpl_dw, cpl_dw_o);
        check("done_o", 32'(exp_q.done), 32'(done_o));
        check("err_o", 32'(exp_q.err), 32'(err_o));
        if (exp_q.chk_hwm) check("hwm_cnt_o", exp_q.hwm_cnt, 32'(hwm_cnt_o));
        if (exp_q.chk_seen) check("req_o strobes", exp_q.req_seen, 32'(req_seen));
        if (exp_q.chk_runs) check("req_o runs", 32'd1, 32'(req_runs));
        cmp_req = 1'b0;
      end
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: no finish within %0d cycles, a test is stuck", cycle_limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Sequencing helpers
  // ----------------------------------------------------------------------
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic set_cfg(input int len, input int total, input logic rcb,
                         input logic meter);
    cfg_i.len_dw    = LEN_W'(len);
    cfg_i.pkt_total = CNT_W'(total);
    cfg_i.rcb_128   = rcb;
    cfg_i.metering  = meter;
  endtask

  task automatic begin_test();
    req_seen = 0;
    req_runs = 0;
    idle_cnt = 0;
    req_prev = 1'b0;
    dw_ref   = 0;
    err_base = err_cnt;
    exp_q    = '0;
  endtask

  task automatic compare_outputs();
    cmp_req = 1'b1;
    do begin
      @(posedge clk);
    end while (cmp_req);
    #1;
  endtask

  task automatic stop_run();
    start_i   = 1'b0;
    resp_en   = 1'b0;
    meter_mon = 1'b0;
    dw_mon    = 1'b0;
    init_i    = 1'b1;
    next_cycle();
    init_i    = 1'b0;
    next_cycle();
  endtask

  task automatic report_test(input string name);
    tests_run = tests_run + 1;
    if (err_cnt == err_base) begin
      $display("test %s: pass", name);
    end else begin
      tests_failed = tests_failed + 1;
      $display("test %s: fail, %0d errors", name, err_cnt - err_base);
    end
  endtask

  task automatic wait_req_idle(input int cycles);
    while (req_seen == 0 || idle_cnt < cycles) @(negedge clk);
    next_cycle();
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------
  task automatic run_meter_off(input int len, input int total);
    begin_test();
    set_cfg(len, total, 1'b0, 1'b0);
    start_i = 1'b1;
    wait_req_idle(20);
    exp_q.req_cnt  = 32'(total);
    exp_q.req_seen = 32'(total);
    exp_q.chk_seen = 1'b1;
    exp_q.chk_runs = 1'b1;
    compare_outputs();
    stop_run();
    report_test($sformatf("metering off len %0d total %0d", len, total));
  endtask

  task automatic run_burst(input int len, input int total, input logic rcb);
    int exp_req;
    exp_req = burst_len(len, rcb);
    if (total < exp_req) exp_req = total;
    begin_test();
    set_cfg(len, total, rcb, 1'b1);
    meter_mon = 1'b1;
    start_i   = 1'b1;
    wait_req_idle(20);
    exp_q.req_cnt  = 32'(exp_req);
    exp_q.req_seen = 32'(exp_req);
    exp_q.hwm_cnt  = 32'(burst_len(len, rcb) - 1);
    exp_q.chk_hwm  = 1'b1;
    exp_q.chk_seen = 1'b1;
    exp_q.chk_runs = 1'b1;
    compare_outputs();
    stop_run();
    report_test($sformatf("burst len %0d rcb_128 %0d", len, rcb));
  endtask

  task automatic run_with_cpl(input int len, input int total, input logic rcb);
    begin_test();
    set_cfg(len, total, rcb, 1'b1);
    dw_target = total * len;
    dw_mon    = 1'b1;
    meter_mon = 1'b1;
    resp_en   = 1'b1;
    start_i   = 1'b1;
    while (!done_o) @(negedge clk);
    next_cycle();
    exp_q.req_cnt  = 32'(total);
    exp_q.cpl_dw   = 32'(total * len);
    exp_q.done     = 1'b1;
    exp_q.req_seen = 32'(total);
    exp_q.chk_seen = 1'b1;
    compare_outputs();
    stop_run();
    report_test($sformatf("completions len %0d total %0d", len, total));
  endtask

  task automatic run_bad_cpl(input int kind);
    int i;
    begin_test();
    set_cfg(16, 12, 1'b0, 1'b1);
    bad_kind = kind;
    resp_en  = 1'b1;
    start_i  = 1'b1;
    while (!err_o) @(negedge clk);
    for (i = 0; i < 10; i++) begin
      @(negedge clk);
      check("err_o", 32'd1, 32'(err_o));   // Sticky until init
    end
    next_cycle();
    stop_run();
    exp_q.chk_hwm = 1'b1;                   // Everything back at zero
    compare_outputs();
    report_test((kind == 1) ? "poisoned completion" : "zero-length completion");
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    int i;
    int r;
    init_i       = 1'b0;
    start_i      = 1'b0;
    cfg_i        = '0;
    cpl_i        = '0;
    cpl_next     = '0;
    seed         = 32'h8744_a1e3;
    err_cnt      = 0;
    err_base     = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycle_cnt    = 0;
    pending      = 0;
    gap_left     = 0;
    resp_en      = 1'b0;
    bad_kind     = 0;
    meter_mon    = 1'b0;
    dw_mon       = 1'b0;
    dw_ref       = 0;
    dw_target    = 0;
    cmp_req      = 1'b0;
    begin_test();
    sweep_len = '{1, 16, 17, 64, 65, 200};

    // Run length budget over all tests
    cycle_limit = 200 + budget(4, 10);
    for (r = 0; r < 2; r++) begin
      for (i = 0; i < 6; i++) begin
        cycle_limit = cycle_limit + budget(sweep_len[i], sweep_total(sweep_len[i]));
      end
    end
    cycle_limit = cycle_limit + budget(16, 12) + budget(100, 6) + budget(1, 30);
    cycle_limit = cycle_limit + 2 * budget(16, 12);

    @(posedge rst_n);
    next_cycle();

    run_meter_off(4, 10);
    for (r = 0; r < 2; r++) begin
      for (i = 0; i < 6; i++) begin
        run_burst(sweep_len[i], sweep_total(sweep_len[i]), (r == 1));
      end
    end
    run_with_cpl(16, 12, 1'b0);
    run_with_cpl(100, 6, 1'b1);
    run_with_cpl(1, 30, 1'b1);
    run_bad_cpl(1);
    run_bad_cpl(2);

    $display("summary: %0d tests run, %0d failed, %0d check errors",
             tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: hw/cpl_tracker.sv
/*
 * Completion tracker
 *   - running total of received completion DWs
 *   - malformed / poisoned classification, one-cycle flags
 *   - sticky error and run-done detection
 */
`timescale 1ns/10ps

module cpl_tracker
  import dma_rd_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            init_i,
  input  rd_cfg_t         cfg_i,
  input  cpl_t            cpl_i,
  output logic [DW_W-1:0] cpl_dw_o,     // DWs received so far
  output logic            malformed_o,  // Bad length seen last cycle
  output logic            data_err_o,   // Poisoned completion seen last cycle
  output logic            err_o,        // Sticky until init
  output logic            done_o        // All expected data in
);

  logic [DW_W-1:0] cpl_dw;
  logic [DW_W-1:0] cpl_dw_nxt;
  logic [DW_W-1:0] dw_expected;
  logic            bad_len;
  logic            poison;
  logic            malformed_q;
  logic            data_err_q;
  logic            err_q;
  logic            done_q;

  // ----------------------------------------------------------------------
  // Classification of the incoming completion
  // ----------------------------------------------------------------------
  assign bad_len = cpl_i.valid &
                   ((cpl_i.len_dw == '0) || (cpl_i.len_dw > cfg_i.len_dw));
  assign poison  = cpl_i.valid & cpl_i.poisoned;

  // Total data the run should return
  assign dw_expected = DW_W'(cfg_i.pkt_total) * DW_W'(cfg_i.len_dw);
  assign cpl_dw_nxt  = cpl_dw + DW_W'(cpl_i.len_dw);

  // ----------------------------------------------------------------------
  // Accumulator and flags
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cpl_dw      <= '0;
      malformed_q <= 1'b0;
      data_err_q  <= 1'b0;
      err_q       <= 1'b0;
      done_q      <= 1'b0;
    end else if (init_i) begin
      cpl_dw      <= '0;
      malformed_q <= 1'b0;
      data_err_q  <= 1'b0;
      err_q       <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      malformed_q <= bad_len;                     // Single-cycle flag
      data_err_q  <= poison;
      err_q       <= err_q | bad_len | poison;    // Rises with the flag
      if (cpl_i.valid) begin
        cpl_dw <= cpl_dw_nxt;
        if (cpl_dw_nxt == dw_expected) begin
          done_q <= 1'b1;                         // Rises with cpl_dw
        end
      end
    end
  end

  assign cpl_dw_o    = cpl_dw;
  assign malformed_o = malformed_q;
  assign data_err_o  = data_err_q;
  assign err_o       = err_q;
  assign done_o      = done_q;

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  // Done holds until the run is cleared
  a_done_sticky: assert property (
    @(posedge clk) disable iff (!rst_n)
    (done_o && !init_i) |=> done_o
  );

endmodule

// File: hw/dma_rd_pkg.sv
/*
 * Shared definitions for the DMA read-request path
 *   - width and credit-limit constants
 *   - rd_cfg_t  run configuration struct
 *   - cpl_t     completion strobe struct
 */
package dma_rd_pkg;

  // ----------------------------------------------------------------------
  // Constants
  // ----------------------------------------------------------------------
  localparam int unsigned CPL_LIMIT = 8;   // Credit limit for the first burst
  localparam int unsigned LEN_W     = 11;  // Request length, 1 to 1024 DWs
  localparam int unsigned CNT_W     = 16;  // Request counter
  localparam int unsigned DW_W      = 32;  // Completion DW accumulator

  // ----------------------------------------------------------------------
  // Run configuration, 29 bits
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [LEN_W-1:0] len_dw;     // Length of every read request
    logic [CNT_W-1:0] pkt_total;  // Requests in this run
    logic             rcb_128;    // RCB, 0 = 64B, 1 = 128B
    logic             metering;   // Throttle enable
  } rd_cfg_t;

  // ----------------------------------------------------------------------
  // Completion strobe, 13 bits
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic             valid;      // One cycle per completion
    logic [LEN_W-1:0] len_dw;     // Payload length
    logic             poisoned;   // EP bit
  } cpl_t;

endpackage

// File: hw/dma_rd_top.sv
/*
 * DMA read-request path, top level
 *   - request generator, read throttle, completion tracker
 */
`timescale 1ns/10ps

module dma_rd_top
  import dma_rd_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             init_i,
  input  logic             start_i,
  input  rd_cfg_t          cfg_i,
  input  cpl_t             cpl_i,
  output logic             req_o,
  output logic [CNT_W-1:0] req_cnt_o,
  output logic [DW_W-1:0]  cpl_dw_o,
  output logic [CNT_W-1:0] hwm_cnt_o,
  output logic             done_o,
  output logic             err_o
);

  logic             mrd_work;
  logic [CNT_W-1:0] req_cnt;
  logic [DW_W-1:0]  cpl_dw;
  logic             malformed;
  logic             data_err;

  // ----------------------------------------------------------------------
  // Request side
  // ----------------------------------------------------------------------
  mrd_req_gen u_req_gen (
    .clk        (clk),
    .rst_n      (rst_n),
    .init_i     (init_i),
    .cfg_i      (cfg_i),
    .mrd_work_i (mrd_work),
    .req_o      (req_o),
    .req_cnt_o  (req_cnt)
  );

  mrd_throttle u_throttle (
    .clk         (clk),
    .rst_n       (rst_n),
    .init_i      (init_i),
    .start_i     (start_i),
    .cfg_i       (cfg_i),
    .req_cnt_i   (req_cnt),
    .cpl_dw_i    (cpl_dw),
    .malformed_i (malformed),
    .data_err_i  (data_err),
    .mrd_work_o  (mrd_work),
    .hwm_cnt_o   (hwm_cnt_o),
    .hwm_dw_o    (),            // Observed inside the throttle only
    .cpl_found_o ()
  );

  // ----------------------------------------------------------------------
  // Completion side
  // ----------------------------------------------------------------------
  cpl_tracker u_cpl_tracker (
    .clk         (clk),
    .rst_n       (rst_n),
    .init_i      (init_i),
    .cfg_i       (cfg_i),
    .cpl_i       (cpl_i),
    .cpl_dw_o    (cpl_dw),
    .malformed_o (malformed),
    .data_err_o  (data_err),
    .err_o       (err_o),
    .done_o      (done_o)
  );

  assign req_cnt_o = req_cnt;
  assign cpl_dw_o  = cpl_dw;

endmodule

// File: hw/mrd_req_gen.sv
/*
 * Memory-read request generator
 *   - one request strobe per permitted cycle
 *   - counts requests sent, stops at the programmed total
 */
`timescale 1ns/10ps

module mrd_req_gen
  import dma_rd_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             init_i,      // Clears the run
  input  rd_cfg_t          cfg_i,
  input  logic             mrd_work_i,  // Issue permit from throttle
  output logic             req_o,
  output logic [CNT_W-1:0] req_cnt_o
);

  logic [CNT_W-1:0] req_cnt;
  logic             more_left;

  // ----------------------------------------------------------------------
  // Request strobe
  // ----------------------------------------------------------------------
  assign more_left = (req_cnt < cfg_i.pkt_total);  // Still requests to send
  assign req_o     = mrd_work_i & more_left;       // Pauses while throttled

  // ----------------------------------------------------------------------
  // Sent counter, moves on the same edge as the strobe
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_cnt <= '0;
    end else if (init_i) begin
      req_cnt <= '0;
    end else if (req_o) begin
      req_cnt <= req_cnt + 1'b1;
    end
  end

  assign req_cnt_o = req_cnt;

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  // A request always consumes a permit from the throttle
  a_req_needs_permit: assert property (
    @(posedge clk) disable iff (!rst_n)
    req_o |-> mrd_work_i
  );

endmodule

// File: hw/mrd_throttle.sv
/*
 * Read metering unit
 *   - initial burst size from request length and RCB
 *   - high-water marks for request count and completion data
 *   - widens the window by one request per matched completion
 *   - falls back to reset marks on a bad completion
 */
`timescale 1ns/10ps

module mrd_throttle
  import dma_rd_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             init_i,
  input  logic             start_i,      // Work enable level
  input  rd_cfg_t          cfg_i,
  input  logic [CNT_W-1:0] req_cnt_i,    // Requests sent so far
  input  logic [DW_W-1:0]  cpl_dw_i,     // Completion DWs so far
  input  logic             malformed_i,
  input  logic             data_err_i,
  output logic             mrd_work_o,   // Issue permit
  output logic [CNT_W-1:0] hwm_cnt_o,
  output logic [DW_W-1:0]  hwm_dw_o,
  output logic             cpl_found_o
);

  localparam logic [DW_W-1:0] HWM_DW_RST = '1;

  logic [CNT_W-1:0] hwm_cnt;     // Requests allowed
  logic [DW_W-1:0]  hwm_dw;      // Data needed before next window step
  logic             found_q;
  logic             cpl_found;
  logic             mrd_work;
  logic [CNT_W-1:0] burst_cnt;

  // ----------------------------------------------------------------------
  // Initial burst table
  // ----------------------------------------------------------------------
  function automatic logic [CNT_W-1:0] init_burst(input logic [LEN_W-1:0] len,
                                                  input logic             rcb_128);
    logic [CNT_W-1:0] val;
    if (len == LEN_W'(1)) begin
      val = CNT_W'(CPL_LIMIT);
    end else if (!rcb_128) begin              // 64B RCB
      if (len <= LEN_W'(16))
        val = CNT_W'(CPL_LIMIT / 2);
      else if (len <= LEN_W'(64))
        val = CNT_W'(CPL_LIMIT / 4);
      else
        val = CNT_W'(CPL_LIMIT / 8);
    end else begin                            // 128B RCB
      if (len <= LEN_W'(32))
        val = CNT_W'(CPL_LIMIT / 2);
      else if (len <= LEN_W'(128))
        val = CNT_W'(CPL_LIMIT / 4);
      else
        val = CNT_W'(CPL_LIMIT / 8);
    end
    return val;
  endfunction

  assign burst_cnt = init_burst(cfg_i.len_dw, cfg_i.rcb_128);

  // ----------------------------------------------------------------------
  // Completion match, registered
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      found_q <= 1'b0;
    end else if (init_i) begin
      found_q <= 1'b0;
    end else begin
      found_q <= (req_cnt_i == CNT_W'(hwm_cnt + 1'b1)) && (cpl_dw_i >= hwm_dw);
    end
  end

  assign cpl_found = found_q & ~mrd_work;  // Only while issue is held off

  // ----------------------------------------------------------------------
  // High-water marks
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hwm_cnt <= '0;
      hwm_dw  <= HWM_DW_RST;
    end else if (init_i) begin
      hwm_cnt <= '0;
      hwm_dw  <= HWM_DW_RST;
    end else if (start_i) begin
      if (hwm_cnt == '0) begin
        hwm_cnt <= burst_cnt;                         // Initial burst
        hwm_dw  <= DW_W'(cfg_i.len_dw);
      end else if (malformed_i || data_err_i) begin
        hwm_cnt <= '0;                                // Back to the start
        hwm_dw  <= HWM_DW_RST;
      end else if (cpl_found) begin
        hwm_cnt <= hwm_cnt + 1'b1;                    // One more request
        hwm_dw  <= hwm_dw + DW_W'(cfg_i.len_dw);
      end
    end
  end

  // ----------------------------------------------------------------------
  // Issue permit
  // ----------------------------------------------------------------------
  assign mrd_work = cfg_i.metering ? (start_i & (hwm_cnt >= req_cnt_i)) : start_i;

  assign mrd_work_o  = mrd_work;
  assign hwm_cnt_o   = hwm_cnt;
  assign hwm_dw_o    = hwm_dw;
  assign cpl_found_o = cpl_found;

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  // A window step never coincides with an issue permit
  a_found_vs_work: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(cpl_found_o && mrd_work_o)
  );

endmodule

// File: list.f
hw/dma_rd_pkg.sv
hw/mrd_req_gen.sv
hw/cpl_tracker.sv
hw/mrd_throttle.sv
hw/dma_rd_top.sv
dv/tb_clk_gen.sv
dv/tb_dma_rd.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the DMA read-path testbench with Verilator.
# The run fails if the log holds the fail message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f list.f --top-module tb_dma_rd -o sim_dma_rd \
  && ./obj_dir/sim_dma_rd > "$LOG" 2>&1 \
  || { cat "$LOG" 2>/dev/null; echo "build or simulation error"; exit 1; }

cat "$LOG"

grep -q "TESTS FAILED" "$LOG" \
  && { echo "simulation reported failure"; exit 1; } \
  || { echo "simulation clean"; exit 0; }
